// ==== Bender.yml ====
package:
  name: l1_cache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/l1_cache_pkg.sv
      - rtl/cache_array.sv
      - rtl/cache_ctrl.sv
      - rtl/l1_cache.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/mem_model.sv
      - tb/tb_l1_cache.sv

// ==== l1_cache.f ====
+incdir+rtl
rtl/l1_cache_pkg.sv
rtl/cache_array.sv
rtl/cache_ctrl.sv
rtl/l1_cache.sv
tb/mem_model.sv
tb/tb_l1_cache.sv

// ==== rtl/cache_array.sv ====
`timescale 1ns/1ps

`include "l1_cache_consts.svh"

module cache_array
    import l1_cache_pkg::*;
(
    input  logic                 CLK,
    input  logic                 nRST,
    input  cache_addr_t          lookup_addr,   // tag compare address
    input  logic [`SET_BITS-1:0] rd_set,        // set shown on rd_frames
    input  array_wr_t            wr,
    output logic                 hit,
    output logic                 hit_way,
    output cache_set_t           rd_frames,
    output logic                 victim_way
);

    // frame storage and per-set lru
    cache_set_t          sets [`N_SETS];
    logic [`N_SETS-1:0]  last_used;     // way touched most recently

    cache_set_t lk_set;                 // set addressed by the lookup

    assign lk_set = sets[lookup_addr.f.set];

    // tag compare across both ways
    always_comb begin
        hit     = 1'b0;
        hit_way = 1'b0;
        for (int w = 0; w < `ASSOC; w++) begin
            if (lk_set[w].valid && (lk_set[w].tag == lookup_addr.f.tag)) begin
                hit     = 1'b1;
                hit_way = w[0];
            end
        end
    end

    // two ways, so the victim is simply the other one
    assign victim_way = ~last_used[lookup_addr.f.set];

    // second read port for bursts and the flush walk
    assign rd_frames = sets[rd_set];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < `N_SETS; s++) begin
                sets[s] <= '0;              // invalid and clean
            end
            last_used <= '0;
        end else if (wr.en) begin
            // merge enabled lanes only
            for (int b = 0; b < 4; b++) begin
                if (wr.byte_en[b]) begin
                    sets[wr.set][wr.way].data[wr.word][8*b +: 8] <= wr.data[8*b +: 8];
                end
            end

            if (wr.set_valid) begin
                sets[wr.set][wr.way].valid <= 1'b1;
                sets[wr.set][wr.way].tag   <= wr.tag;
            end

            // set wins over clear, they never come together anyway
            if (wr.set_dirty) begin
                sets[wr.set][wr.way].dirty <= 1'b1;
            end else if (wr.clr_dirty) begin
                sets[wr.set][wr.way].dirty <= 1'b0;
            end

            if (wr.touch_lru) begin
                last_used[wr.set] <= wr.way;
            end
        end
    end

endmodule

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/1ps

`include "l1_cache_consts.svh"

module cache_ctrl
    import l1_cache_pkg::*;
(
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 flush,
    output logic                 flush_done,
    input  bus_req_t             proc_req,
    output bus_rsp_t             proc_rsp,
    output bus_req_t             mem_req,
    input  bus_rsp_t             mem_rsp,
    input  logic                 hit,
    input  logic                 hit_way,
    input  cache_set_t           rd_frames,
    input  logic                 victim_way,
    output cache_addr_t          lookup_addr,
    output logic [`SET_BITS-1:0] rd_set,
    output array_wr_t            wr
);

    localparam int LAST_WORD = `BLOCK_SIZE - 1;
    localparam int LAST_SET  = `N_SETS - 1;
    localparam int LAST_WAY  = `ASSOC - 1;

    typedef enum logic [2:0] {
        IDLE, WB, FETCH, FLUSH_SCAN, FLUSH_WB
    } state_t;

    state_t                 state, next_state;
    logic [`BLOCK_BITS-1:0] word_cnt, next_word_cnt;
    logic                   way_cnt, next_way_cnt;
    logic [`SET_BITS-1:0]   set_cnt, next_set_cnt;
    cache_addr_t            addr_q, next_addr;      // word aligned burst address

    logic         req;          // processor wants something
    logic         pass;         // uncached region
    logic         last_word;
    cache_frame_t cur_frame;    // frame under the counters
    cache_frame_t victim;       // lookup set victim while idle
    cache_addr_t  blk_base;     // block base of the processor address

    assign lookup_addr.raw = proc_req.addr;
    assign req       = proc_req.ren | proc_req.wen;
    assign pass      = (proc_req.addr >= `NONCACHE_START_ADDR);
    assign last_word = (word_cnt == LAST_WORD[`BLOCK_BITS-1:0]);

    // lookup set in idle and counter set in bursts
    assign rd_set    = (state == IDLE) ? lookup_addr.f.set : set_cnt;
    assign cur_frame = rd_frames[way_cnt];
    assign victim    = rd_frames[victim_way];

    always_comb begin
        blk_base             = lookup_addr;
        blk_base.f.block     = '0;
        blk_base.f.byte_off  = 2'b00;
    end

    always_comb begin
        next_state    = state;
        next_word_cnt = word_cnt;
        next_way_cnt  = way_cnt;
        next_set_cnt  = set_cnt;
        next_addr     = addr_q;

        proc_rsp       = '0;
        proc_rsp.busy  = 1'b1;
        mem_req        = '0;
        mem_req.addr   = addr_q.raw;
        mem_req.wdata  = cur_frame.data[word_cnt];
        mem_req.byte_en = 4'hf;         // bursts move whole words
        flush_done     = 1'b0;

        wr         = '0;
        wr.set     = set_cnt;
        wr.way     = way_cnt;
        wr.word    = word_cnt;
        wr.data    = mem_rsp.rdata;
        wr.tag     = lookup_addr.f.tag;

        case (state)
            IDLE: begin
                proc_rsp.busy = req;            // nothing asked means not busy
                if (req && pass) begin
                    mem_req  = proc_req;        // straight through
                    proc_rsp = mem_rsp;
                end else if (req && hit) begin
                    proc_rsp.busy  = 1'b0;
                    proc_rsp.rdata = rd_frames[hit_way].data[lookup_addr.f.block];
                    wr.en        = 1'b1;
                    wr.set       = lookup_addr.f.set;
                    wr.way       = hit_way;
                    wr.word      = lookup_addr.f.block;
                    wr.data      = proc_req.wdata;
                    wr.byte_en   = proc_req.wen ? proc_req.byte_en : 4'h0;
                    wr.set_dirty = proc_req.wen;
                    wr.touch_lru = 1'b1;
                end else if (req) begin
                    // a miss locks the victim into the counters
                    next_way_cnt  = victim_way;
                    next_set_cnt  = lookup_addr.f.set;
                    next_word_cnt = '0;
                    if (victim.dirty) begin
                        next_addr       = blk_base;
                        next_addr.f.tag = victim.tag;   // old block address
                        next_state      = WB;
                    end else begin
                        next_addr  = blk_base;
                        next_state = FETCH;
                    end
                end else if (flush) begin
                    next_way_cnt = 1'b0;
                    next_set_cnt = '0;
                    next_state   = FLUSH_SCAN;
                end
            end

            // both write-back flavours push the frame at the counters
            WB, FLUSH_WB: begin
                mem_req.wen = 1'b1;
                if (!mem_rsp.busy) begin
                    next_word_cnt = word_cnt + 1'b1;
                    next_addr.raw = addr_q.raw + 32'd4;
                    if (last_word) begin
                        wr.en        = 1'b1;
                        wr.clr_dirty = 1'b1;
                        if (state == WB) begin
                            next_addr  = blk_base;  // now fetch the new block
                            next_state = FETCH;
                        end else begin
                            next_state = FLUSH_SCAN; // revisit the now clean frame
                        end
                    end
                end
            end

            FETCH: begin
                mem_req.ren = 1'b1;
                if (!mem_rsp.busy) begin
                    wr.en         = 1'b1;
                    wr.byte_en    = 4'hf;
                    next_word_cnt = word_cnt + 1'b1;
                    next_addr.raw = addr_q.raw + 32'd4;
                    if (last_word) begin
                        wr.set_valid = 1'b1;        // tag goes live with the last word
                        next_state   = IDLE;
                    end
                end
            end

            FLUSH_SCAN: begin
                if (cur_frame.dirty) begin
                    next_word_cnt   = '0;
                    next_addr.f.tag = cur_frame.tag;
                    next_addr.f.set = set_cnt;
                    next_addr.f.block    = '0;
                    next_addr.f.byte_off = 2'b00;
                    next_state      = FLUSH_WB;
                end else if ((set_cnt == LAST_SET[`SET_BITS-1:0]) && (way_cnt == LAST_WAY[0])) begin
                    flush_done = 1'b1;              // walk finished
                    next_state = IDLE;
                end else begin
                    next_way_cnt = ~way_cnt;
                    if (way_cnt) begin
                        next_set_cnt = set_cnt + 1'b1;
                    end
                end
            end

            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            word_cnt <= '0;
            way_cnt  <= 1'b0;
            set_cnt  <= '0;
            addr_q   <= '0;
        end else begin
            state    <= next_state;
            word_cnt <= next_word_cnt;
            way_cnt  <= next_way_cnt;
            set_cnt  <= next_set_cnt;
            addr_q   <= next_addr;
        end
    end

endmodule

// ==== rtl/l1_cache.sv ====
`timescale 1ns/1ps

`include "l1_cache_consts.svh"

module l1_cache
    import l1_cache_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  logic     flush,
    output logic     flush_done,
    input  bus_req_t proc_req,
    output bus_rsp_t proc_rsp,
    output bus_req_t mem_req,
    input  bus_rsp_t mem_rsp
);

    // controller <-> array
    cache_addr_t          lookup_addr;
    logic [`SET_BITS-1:0] rd_set;
    array_wr_t            wr;
    logic                 hit;
    logic                 hit_way;
    logic                 victim_way;
    cache_set_t           rd_frames;

    cache_ctrl u_cache_ctrl (
        .CLK         (CLK),
        .nRST        (nRST),
        .flush       (flush),
        .flush_done  (flush_done),
        .proc_req    (proc_req),
        .proc_rsp    (proc_rsp),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .hit         (hit),
        .hit_way     (hit_way),
        .rd_frames   (rd_frames),
        .victim_way  (victim_way),
        .lookup_addr (lookup_addr),
        .rd_set      (rd_set),
        .wr          (wr)
    );

    cache_array u_cache_array (
        .CLK         (CLK),
        .nRST        (nRST),
        .lookup_addr (lookup_addr),
        .rd_set      (rd_set),
        .wr          (wr),
        .hit         (hit),
        .hit_way     (hit_way),
        .rd_frames   (rd_frames),
        .victim_way  (victim_way)
    );

endmodule

// ==== rtl/l1_cache_consts.svh ====
`ifndef L1_CACHE_CONSTS_SVH
`define L1_CACHE_CONSTS_SVH

// cache geometry, all sizes are powers of two
`define WORD_SIZE   32       // bits per word
`define CACHE_SIZE  1024     // bytes of data storage
`define BLOCK_SIZE  2        // words per block
`define ASSOC       2        // ways per set, lru bit only covers two

// derived sizes, kept in step with the ones above by hand
`define N_SETS      (`CACHE_SIZE / (`BLOCK_SIZE * `WORD_SIZE / 8) / `ASSOC)
`define SET_BITS    6        // log2 of N_SETS
`define BLOCK_BITS  1        // log2 of BLOCK_SIZE
`define TAG_BITS    23       // word size minus set, block and byte bits

// address map
// everything from here up bypasses the cache
`define NONCACHE_START_ADDR 32'h8000_0000

`endif

// ==== rtl/l1_cache_pkg.sv ====
`include "l1_cache_consts.svh"

package l1_cache_pkg;

    typedef logic [`WORD_SIZE-1:0] word_t;

    // request side of either bus
    typedef struct packed {
        logic       ren;
        logic       wen;
        word_t      addr;
        word_t      wdata;
        logic [3:0] byte_en;    // one bit per byte lane
    } bus_req_t;

    // response side of either bus
    typedef struct packed {
        word_t rdata;
        logic  busy;            // request completes on an edge with busy low
    } bus_rsp_t;

    // processor address, raw or split into cache fields
    typedef struct packed {
        logic [`TAG_BITS-1:0]   tag;
        logic [`SET_BITS-1:0]   set;
        logic [`BLOCK_BITS-1:0] block;  // word within the block
        logic [1:0]             byte_off;
    } cache_addr_fields_t;

    typedef union packed {
        word_t              raw;
        cache_addr_fields_t f;
    } cache_addr_t;

    typedef struct packed {
        logic                       valid;
        logic                       dirty;
        logic [`TAG_BITS-1:0]       tag;
        word_t [`BLOCK_SIZE-1:0]    data;
    } cache_frame_t;

    typedef cache_frame_t [`ASSOC-1:0] cache_set_t;

    // one write command per cycle into the frame array
    typedef struct packed {
        logic                   en;
        logic [`SET_BITS-1:0]   set;
        logic                   way;
        logic [`BLOCK_BITS-1:0] word;
        word_t                  data;
        logic [3:0]             byte_en;    // zero for tag/flag only updates
        logic                   set_valid;  // also loads tag below
        logic [`TAG_BITS-1:0]   tag;
        logic                   set_dirty;
        logic                   clr_dirty;
        logic                   touch_lru;  // mark way as most recently used
    } array_wr_t;

endpackage

// ==== tb/mem_model.sv ====
`timescale 1ns/1ps

`include "l1_cache_consts.svh"

module mem_model
    import l1_cache_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  bus_req_t mem_req,
    output bus_rsp_t mem_rsp
);

    localparam int    MEM_WORDS = 2048;
    localparam word_t LFSR_SEED = 32'hea43_27ba;

    word_t mem [MEM_WORDS];     // index top bit is addr[31]
    word_t lfsr_q;
    word_t lfsr_1, lfsr_2;      // one and two steps ahead
    logic  stall;
    int    idx;

    function automatic int word_index(input word_t addr);
        return int'({addr[31], addr[11:2]});
    endfunction

    // spreads every address bit over the word
    function automatic word_t fill_pattern(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
    endfunction

    function automatic word_t lfsr_step(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_pattern({i[10], 19'b0, i[9:0], 2'b00});
        end
    end

    assign idx    = word_index(mem_req.addr);
    assign lfsr_1 = lfsr_step(lfsr_q);
    assign lfsr_2 = lfsr_step(lfsr_1);

    assign mem_rsp.busy  = (mem_req.ren | mem_req.wen) & stall;
    assign mem_rsp.rdata = mem[idx];    // combinational read

    // two bits per cycle, stall about one cycle in four
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lfsr_q <= LFSR_SEED;
            stall  <= 1'b0;
        end else begin
            lfsr_q <= lfsr_2;
            stall  <= lfsr_q[0] & lfsr_1[0];
        end
    end

    always @(posedge CLK) begin
        if (mem_req.wen && !mem_rsp.busy) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_req.byte_en[b]) mem[idx][8*b +: 8] <= mem_req.wdata[8*b +: 8];
            end
        end
    end

endmodule

// ==== tb/tb_l1_cache.sv ====
`timescale 1ns/1ps

`include "l1_cache_consts.svh"

module tb_l1_cache
    import l1_cache_pkg::*;
();

    localparam int    WAIT_LIMIT = 2000;    // cycles per wait loop
    localparam int    MEM_WORDS  = 2048;
    localparam word_t LFSR_SEED  = 32'hea43_27ba;

    logic     CLK, nRST, flush, flush_done;
    bus_req_t proc_req, mem_req;
    bus_rsp_t proc_rsp, mem_rsp;
    word_t    lfsr_q;
    word_t    shadow [MEM_WORDS];   // memory as the core should see it
    word_t    written_q [$];        // every address written so far

    l1_cache u_l1_cache (.CLK, .nRST, .flush, .flush_done,
                         .proc_req, .proc_rsp, .mem_req, .mem_rsp);

    mem_model u_mem_model (.CLK, .nRST, .mem_req, .mem_rsp);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;      // 4 ns period
    end

    function automatic int word_index(input word_t addr);
        return int'({addr[31], addr[11:2]});
    endfunction

    function automatic word_t fill_pattern(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
    endfunction

    function automatic word_t lfsr_step(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);     // one step per bit
        end
        return v;
    endfunction

    function automatic word_t merge_lanes(input word_t old, input word_t wdata,
                                          input logic [3:0] be);
        word_t w = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) w[8*b +: 8] = wdata[8*b +: 8];
        end
        return w;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %0t: %s, got %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    // one request held until busy is seen low mid-cycle
    task automatic access(input logic is_wr, input word_t addr, input word_t wdata,
                          input logic [3:0] be, output word_t rdata, output int waits);
        bus_req_t req = '{ren: ~is_wr, wen: is_wr, addr: addr, wdata: wdata, byte_en: be};
        waits = 0;
        @(posedge CLK);
        proc_req <= req;
        @(negedge CLK);
        while (proc_rsp.busy) begin
            waits++;
            if (waits > WAIT_LIMIT) abort_run($sformatf("cache stuck busy on %h", addr));
            @(negedge CLK);
        end
        rdata = proc_rsp.rdata;
        if (is_wr) begin
            shadow[word_index(addr)] = merge_lanes(shadow[word_index(addr)], wdata, be);
            written_q.push_back(addr);
        end
        @(posedge CLK);     // request completes here
        proc_req <= '0;
    endtask

    task automatic read_check(input word_t addr, input string what, output int waits);
        word_t d;
        access(1'b0, addr, '0, 4'h0, d, waits);
        check(d, shadow[word_index(addr)], what);
    endtask

    task automatic write_rand(input word_t addr, input logic [3:0] be, output int waits);
        word_t d;
        access(1'b1, addr, rand_bits(32), be, d, waits);
    endtask

    task automatic read_miss_then_hit();
        int w;
        read_check(32'h0000_0044, "read miss data", w);
        read_check(32'h0000_0044, "read hit data", w);
        check(w, 0, "read hit took extra cycles");
    endtask

    // alternates between both words of the block in set 9
    task automatic byte_enable_writes();
        logic [3:0] lanes [5] = '{4'b0001, 4'b0110, 4'b1000, 4'b1011, 4'b1111};
        int w;
        read_check(32'h0000_0048, "fill before byte writes", w);
        foreach (lanes[i]) begin
            write_rand(32'h0000_0048 + 4 * (i % 2), lanes[i], w);
            check(w, 0, "write hit took extra cycles");
            read_check(32'h0000_0048 + 4 * (i % 2), "merged word", w);
        end
    endtask

    // A, B and C share set 2 and B is least recently used when C arrives
    task automatic lru_eviction();
        word_t a = 32'h0000_0010;
        word_t b = 32'h0000_0210;
        word_t c = 32'h0000_0410;
        int    w;
        write_rand(a, 4'hf, w);
        write_rand(b, 4'hf, w);
        read_check(a, "reread of A", w);
        read_check(c, "read of C", w);
        check(u_mem_model.mem[word_index(b)], shadow[word_index(b)], "B written back");
        read_check(a, "A after eviction of B", w);
        check(w, 0, "A missed after eviction of B");
    endtask

    task automatic uncached_access();
        word_t a = 32'h8000_0104;
        int    w;
        read_check(32'h8000_0100, "uncached read", w);
        write_rand(a, 4'b1101, w);
        @(negedge CLK);     // memory write lands on the completing edge
        check(u_mem_model.mem[word_index(a)], shadow[word_index(a)], "uncached write");
        read_check(a, "uncached readback", w);
    endtask

    task automatic flush_all();
        int w;
        int n = 0;
        for (int s = 0; s < 4; s++) begin
            write_rand(32'h0000_0080 + 8 * s, 4'hf, w);     // sets 16 to 19
        end
        write_rand(32'h0000_0284, 4'hf, w);     // second way of set 16
        @(posedge CLK);
        flush <= 1'b1;
        @(negedge CLK);
        while (!flush_done) begin
            n++;
            if (n > WAIT_LIMIT) abort_run("flush_done never arrived");
            @(negedge CLK);
        end
        @(posedge CLK);
        flush <= 1'b0;
        @(negedge CLK);
        check(flush_done, 1'b0, "flush_done wider than one cycle");
        foreach (written_q[i]) begin
            check(u_mem_model.mem[word_index(written_q[i])],
                  shadow[word_index(written_q[i])], "memory after flush");
            read_check(written_q[i], "reread after flush", w);
        end
    endtask

    initial begin
        proc_req = '0;
        flush    = 1'b0;
        nRST     = 1'b0;
        lfsr_q   = LFSR_SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = fill_pattern({i[10], 19'b0, i[9:0], 2'b00});
        end
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check(mem_req.ren | mem_req.wen, 1'b0, "memory bus active after reset");
        check(flush_done, 1'b0, "flush_done high after reset");
        check(proc_rsp.busy, 1'b0, "busy high with no request");
        read_miss_then_hit();
        byte_enable_writes();
        lru_eviction();
        uncached_access();
        flush_all();
        $display("Done: no errors");
        $finish;
    end

endmodule
